// ==== hdl/img_filter_defines.svh ====
// shared widths and APB register offsets, included by every filter RTL file that needs them
`ifndef IMG_FILTER_DEFINES_SVH
`define IMG_FILTER_DEFINES_SVH

// pixel width in bits
`define PIX_W 12

// longest line the buffers can hold, also the buffer depth
`define LINE_MAX 256

// room for the sum of 49 full-scale pixels
`define SUM_W (`PIX_W + 6)

// APB byte offsets
`define REG_CTRL 4'h0
`define REG_STATUS 4'h4
`define REG_WIDTH 4'h8

`endif

// ==== hdl/img_filter_pkg.sv ====
// type package for the image filter, imported by the CSR block, the kernel and the top level
`default_nettype none

package img_filter_pkg;

    // neighbourhood selected by the kernel stage
    // encoding 2'b11 is reserved and never stored
    typedef enum logic [1:0] {
        MODE_CENTER = 2'd0,
        MODE_BOX3   = 2'd1,
        MODE_BOX7   = 2'd2
    } kernel_mode_e;

    // APB transfer phase seen by the slave
    typedef enum logic [1:0] {
        APB_IDLE   = 2'd0,
        APB_SETUP  = 2'd1,
        APB_ACCESS = 2'd2
    } apb_state_e;

endpackage

`default_nettype wire

// ==== hdl/filter_csr_decode.sv ====
// APB slave for the filter, holds CTRL and WIDTH and collects frame and line-length status
`timescale 1ns/100ps
`default_nettype none
`include "img_filter_defines.svh"

module filter_csr_decode (
    input  wire                                clk,
    input  wire                                arst_n_i,
    input  wire                                psel_i,
    input  wire                                penable_i,
    input  wire                                pwrite_i,
    input  wire [3:0]                          paddr_i,
    input  wire [31:0]                         pwdata_i,
    output logic [31:0]                        prdata_o,
    output logic                               pready_o,
    output logic                               pslverr_o,
    input  wire                                vs_i,
    input  wire                                line_done_i,
    input  wire [$clog2(`LINE_MAX):0]          line_len_i,
    output logic                               cfg_en_o,
    output img_filter_pkg::kernel_mode_e       cfg_mode_o,
    output logic [3:0]                         cfg_shift_o,
    output logic [$clog2(`LINE_MAX):0]         cfg_width_o
);
    import img_filter_pkg::*;

    localparam int LEN_W = $clog2(`LINE_MAX) + 1;

    apb_state_e   apb_state;
    logic         access;
    logic         wr_acc;
    logic         sel_ctrl;
    logic         sel_status;
    logic         sel_width;
    kernel_mode_e wr_mode;
    logic [15:0]  frame_cnt;
    logic         len_err;
    logic         vs_q;

    // ----------------------------------------
    // APB phase and address decode
    // ----------------------------------------
    always_comb begin
        if (!psel_i) begin
            apb_state = APB_IDLE;
        end else if (!penable_i) begin
            apb_state = APB_SETUP;
        end else begin
            apb_state = APB_ACCESS;
        end
    end

    assign access     = (apb_state == APB_ACCESS);
    assign wr_acc     = access & pwrite_i;
    assign sel_ctrl   = (paddr_i == `REG_CTRL);
    assign sel_status = (paddr_i == `REG_STATUS);
    assign sel_width  = (paddr_i == `REG_WIDTH);

    // no wait states
    assign pready_o  = 1'b1;
    assign pslverr_o = access & ~(sel_ctrl | sel_status | sel_width);

    // reserved mode code falls back to centre pixel
    always_comb begin
        case (pwdata_i[5:4])
            2'd1:    wr_mode = MODE_BOX3;
            2'd2:    wr_mode = MODE_BOX7;
            default: wr_mode = MODE_CENTER;
        endcase
    end

    // CTRL layout: [0] enable, [5:4] mode, [11:8] shift
    always_comb begin
        prdata_o = '0;
        if (access && !pwrite_i) begin
            if (sel_ctrl) begin
                prdata_o = {20'd0, cfg_shift_o, 2'd0, cfg_mode_o, 3'd0, cfg_en_o};
            end else if (sel_status) begin
                prdata_o = {15'd0, len_err, frame_cnt};
            end else if (sel_width) begin
                prdata_o = {{(32 - LEN_W){1'b0}}, cfg_width_o};
            end
        end
    end

    // ----------------------------------------
    // configuration and status registers
    // ----------------------------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cfg_en_o    <= 1'b0;
            cfg_mode_o  <= MODE_CENTER;
            cfg_shift_o <= '0;
            cfg_width_o <= '0;
            frame_cnt   <= '0;
            len_err     <= 1'b0;
            vs_q        <= 1'b0;
        end else begin
            if (wr_acc && sel_ctrl) begin
                cfg_en_o    <= pwdata_i[0];
                cfg_mode_o  <= wr_mode;
                cfg_shift_o <= pwdata_i[11:8];
            end
            if (wr_acc && sel_width) begin
                cfg_width_o <= pwdata_i[LEN_W-1:0];
            end
            vs_q <= vs_i;
            // count frames on the trailing edge of vs
            if (vs_q && !vs_i && cfg_en_o) begin
                frame_cnt <= frame_cnt + 16'd1;
            end
            // a new mismatch wins over a clear in the same cycle
            if (line_done_i && (line_len_i != cfg_width_o)) begin
                len_err <= 1'b1;
            end else if (wr_acc && sel_status && pwdata_i[16]) begin
                len_err <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/window_7x7.sv ====
// builds the 7x7 pixel window from the raster stream using six cascaded line buffers
`timescale 1ns/100ps
`default_nettype none
`include "img_filter_defines.svh"

module window_7x7 (
    input  wire                           clk,
    input  wire                           arst_n_i,
    input  wire                           cfg_en_i,
    input  wire [$clog2(`LINE_MAX):0]     cfg_width_i,
    input  wire [`PIX_W-1:0]              pix_i,
    input  wire                           de_i,
    input  wire                           hs_i,
    input  wire                           vs_i,
    output logic [49*`PIX_W-1:0]          win_o,
    output logic                          win_valid_o,
    output logic                          vs_d_o,
    output logic                          line_done_o,
    output logic [$clog2(`LINE_MAX):0]    line_len_o
);

    localparam int AW    = $clog2(`LINE_MAX);
    localparam int LEN_W = AW + 1;

    logic              acc;
    logic              blank;
    logic              line_end;
    logic              pos_ok;
    logic [LEN_W-1:0]  col_cnt;
    logic [2:0]        row_cnt;
    logic              de_d;
    logic              ok_d;
    logic [AW-1:0]     wr_addr;
    logic [`PIX_W-1:0] pix_d;
    logic [`PIX_W-1:0] rd [0:5];
    logic [`PIX_W-1:0] bank_din [0:5];
    logic [`PIX_W-1:0] row_sr [0:6][0:6];
    logic [1:0]        vs_sr;

    // pixel taken only inside an active line while enabled
    assign blank    = hs_i | ~vs_i;
    assign acc      = de_i & cfg_en_i & ~blank;
    assign line_end = blank & (col_cnt != '0);

    // six full rows above and six pixels to the left, inside WIDTH
    assign pos_ok = (row_cnt == 3'd6) && (col_cnt >= 6) && (col_cnt < cfg_width_i);

    // ----------------------------------------
    // line and row position
    // ----------------------------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            col_cnt     <= '0;
            row_cnt     <= '0;
            line_done_o <= 1'b0;
            line_len_o  <= '0;
        end else begin
            line_done_o <= line_end;
            if (line_end) begin
                line_len_o <= col_cnt;
            end
            if (blank) begin
                col_cnt <= '0;
            end else if (acc) begin
                col_cnt <= col_cnt + 1'b1;
            end
            // saturates once the window has its six upper rows
            if (!vs_i) begin
                row_cnt <= '0;
            end else if (line_end && (row_cnt != 3'd6)) begin
                row_cnt <= row_cnt + 3'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            de_d        <= 1'b0;
            ok_d        <= 1'b0;
            win_valid_o <= 1'b0;
            vs_sr       <= '0;
        end else begin
            de_d        <= acc;
            ok_d        <= acc & pos_ok;
            win_valid_o <= ok_d;
            vs_sr       <= {vs_sr[0], vs_i};
        end
    end

    assign vs_d_o = vs_sr[1];

    always_ff @(posedge clk) begin
        if (acc) begin
            pix_d   <= pix_i;
            wr_addr <= col_cnt[AW-1:0];
        end
    end

    // ----------------------------------------
    // line buffers
    // ----------------------------------------
    // read at the pixel cycle, write back one cycle later so each bank
    // passes its old line down to the next bank
    for (genvar k = 0; k < 6; k++) begin : g_lbuf
        logic [`PIX_W-1:0] mem [0:`LINE_MAX-1];

        if (k == 0) begin : g_head
            assign bank_din[k] = pix_d;
        end else begin : g_chain
            assign bank_din[k] = rd[k-1];
        end

        always_ff @(posedge clk) begin
            if (acc) begin
                rd[k] <= mem[col_cnt[AW-1:0]];
            end
            if (de_d) begin
                mem[wr_addr] <= bank_din[k];
            end
        end
    end

    // ----------------------------------------
    // column shift registers
    // ----------------------------------------
    // row 6 is the newest line, column 6 the newest pixel
    always_ff @(posedge clk) begin
        if (de_d) begin
            for (int r = 0; r < 7; r++) begin
                for (int c = 0; c < 6; c++) begin
                    row_sr[r][c] <= row_sr[r][c+1];
                end
            end
            row_sr[6][6] <= pix_d;
            for (int r = 0; r < 6; r++) begin
                row_sr[r][6] <= rd[5-r];
            end
        end
    end

    // row-major packing, top-left pixel in the lowest bits
    always_comb begin
        for (int r = 0; r < 7; r++) begin
            for (int c = 0; c < 7; c++) begin
                win_o[(r*7+c)*`PIX_W +: `PIX_W] = row_sr[r][c];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/kernel_sum.sv ====
// two-stage adder tree giving the centre, 3x3 or 7x7 sum of the window as set by the mode
`timescale 1ns/100ps
`default_nettype none
`include "img_filter_defines.svh"

module kernel_sum (
    input  wire                           clk,
    input  wire                           arst_n_i,
    input  wire                           cfg_en_i,
    input  img_filter_pkg::kernel_mode_e  cfg_mode_i,
    input  wire [49*`PIX_W-1:0]           win_i,
    input  wire                           win_valid_i,
    input  wire                           vs_i,
    output logic [`SUM_W-1:0]             sum_o,
    output logic                          sum_valid_o,
    output logic                          vs_sum_o
);
    import img_filter_pkg::*;

    logic [`PIX_W+2:0] row_sum_c [0:6];
    logic [`PIX_W+3:0] box3_c;
    logic [`PIX_W+2:0] row_sum_q [0:6];
    logic [`PIX_W+3:0] box3_q;
    logic [`PIX_W-1:0] centre_q;
    logic [`SUM_W-1:0] box7_c;
    logic [`SUM_W-1:0] sel_c;
    logic              valid_q;
    logic              vs_q;

    // ----------------------------------------
    // stage 1 row sums and 3x3 partial
    // ----------------------------------------
    always_comb begin
        box3_c = '0;
        for (int r = 0; r < 7; r++) begin
            row_sum_c[r] = '0;
            for (int c = 0; c < 7; c++) begin
                row_sum_c[r] = row_sum_c[r] + win_i[(r*7+c)*`PIX_W +: `PIX_W];
                if ((r >= 2) && (r <= 4) && (c >= 2) && (c <= 4)) begin
                    box3_c = box3_c + win_i[(r*7+c)*`PIX_W +: `PIX_W];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        row_sum_q <= row_sum_c;
        box3_q    <= box3_c;
        centre_q  <= win_i[24*`PIX_W +: `PIX_W];
    end

    // ----------------------------------------
    // stage 2 mode select
    // ----------------------------------------
    always_comb begin
        box7_c = '0;
        for (int r = 0; r < 7; r++) begin
            box7_c = box7_c + row_sum_q[r];
        end
        case (cfg_mode_i)
            MODE_BOX3: sel_c = {{(`SUM_W - `PIX_W - 4){1'b0}}, box3_q};
            MODE_BOX7: sel_c = box7_c;
            default:   sel_c = {{(`SUM_W - `PIX_W){1'b0}}, centre_q};
        endcase
    end

    always_ff @(posedge clk) begin
        sum_o <= sel_c;
    end

    // qualifiers follow the data, dropped as soon as enable goes low
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q     <= 1'b0;
            vs_q        <= 1'b0;
            sum_valid_o <= 1'b0;
            vs_sum_o    <= 1'b0;
        end else begin
            valid_q     <= win_valid_i & cfg_en_i;
            vs_q        <= vs_i & cfg_en_i;
            sum_valid_o <= valid_q & cfg_en_i;
            vs_sum_o    <= vs_q & cfg_en_i;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pixel_normalize.sv ====
// output stage, scales the kernel sum by a right shift and saturates it to the pixel range
`timescale 1ns/100ps
`default_nettype none
`include "img_filter_defines.svh"

module pixel_normalize (
    input  wire                  clk,
    input  wire                  arst_n_i,
    input  wire [3:0]            cfg_shift_i,
    input  wire [`SUM_W-1:0]     sum_i,
    input  wire                  sum_valid_i,
    input  wire                  vs_i,
    output logic [`PIX_W-1:0]    pix_o,
    output logic                 de_o,
    output logic                 vs_o
);

    localparam logic [`SUM_W-1:0] PIX_MAX = {{(`SUM_W - `PIX_W){1'b0}}, {`PIX_W{1'b1}}};

    logic [`SUM_W-1:0] shifted;
    logic [`PIX_W-1:0] clamped;

    assign shifted = sum_i >> cfg_shift_i;

    // saturate anything above full scale
    assign clamped = (shifted > PIX_MAX) ? PIX_MAX[`PIX_W-1:0] : shifted[`PIX_W-1:0];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pix_o <= '0;
            de_o  <= 1'b0;
            vs_o  <= 1'b0;
        end else begin
            pix_o <= clamped;
            de_o  <= sum_valid_i;
            vs_o  <= vs_i;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/img_filter_top.sv ====
// top level of the 7x7 image filter, stream path plus APB configuration block
`timescale 1ns/100ps
`default_nettype none
`include "img_filter_defines.svh"

module img_filter_top (
    input  wire                  clk,
    input  wire                  arst_n_i,
    input  wire                  psel_i,
    input  wire                  penable_i,
    input  wire                  pwrite_i,
    input  wire [3:0]            paddr_i,
    input  wire [31:0]           pwdata_i,
    output logic [31:0]          prdata_o,
    output logic                 pready_o,
    output logic                 pslverr_o,
    input  wire [`PIX_W-1:0]     pix_i,
    input  wire                  de_i,
    input  wire                  hs_i,
    input  wire                  vs_i,
    output logic [`PIX_W-1:0]    pix_o,
    output logic                 de_o,
    output logic                 vs_o
);
    import img_filter_pkg::*;

    logic                          cfg_en;
    kernel_mode_e                  cfg_mode;
    logic [3:0]                    cfg_shift;
    logic [$clog2(`LINE_MAX):0]    cfg_width;
    logic                          line_done;
    logic [$clog2(`LINE_MAX):0]    line_len;
    logic [49*`PIX_W-1:0]          win;
    logic                          win_valid;
    logic                          vs_d;
    logic [`SUM_W-1:0]             sum;
    logic                          sum_valid;
    logic                          vs_sum;

    // ----------------------------------------
    // configuration
    // ----------------------------------------
    filter_csr_decode u_decode (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .vs_i        (vs_i),
        .line_done_i (line_done),
        .line_len_i  (line_len),
        .cfg_en_o    (cfg_en),
        .cfg_mode_o  (cfg_mode),
        .cfg_shift_o (cfg_shift),
        .cfg_width_o (cfg_width)
    );

    // ----------------------------------------
    // stream path, 2 + 2 + 1 cycles
    // ----------------------------------------
    window_7x7 u_window (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .cfg_en_i    (cfg_en),
        .cfg_width_i (cfg_width),
        .pix_i       (pix_i),
        .de_i        (de_i),
        .hs_i        (hs_i),
        .vs_i        (vs_i),
        .win_o       (win),
        .win_valid_o (win_valid),
        .vs_d_o      (vs_d),
        .line_done_o (line_done),
        .line_len_o  (line_len)
    );

    kernel_sum u_execute (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .cfg_en_i    (cfg_en),
        .cfg_mode_i  (cfg_mode),
        .win_i       (win),
        .win_valid_i (win_valid),
        .vs_i        (vs_d),
        .sum_o       (sum),
        .sum_valid_o (sum_valid),
        .vs_sum_o    (vs_sum)
    );

    pixel_normalize u_result (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .cfg_shift_i (cfg_shift),
        .sum_i       (sum),
        .sum_valid_i (sum_valid),
        .vs_i        (vs_sum),
        .pix_o       (pix_o),
        .de_o        (de_o),
        .vs_o        (vs_o)
    );

endmodule

`default_nettype wire

// ==== tb/img_filter_props.sv ====
// concurrent checks on APB error timing and output framing, bound into the filter top level
`timescale 1ns/100ps
`default_nettype none

module img_filter_props (
    input wire clk,
    input wire arst_n_i,
    input wire psel_i,
    input wire penable_i,
    input wire pslverr_i,
    input wire out_de_i,
    input wire out_vs_i
);

    // read by the testbench before it declares the result
    int fail_cnt = 0;

    // slave error only in the access phase of a transfer
    err_in_access: assert property (@(posedge clk) disable iff (!arst_n_i)
        pslverr_i |-> (psel_i && penable_i))
        else begin
            fail_cnt++;
            $error("pslverr_o high outside an APB access cycle");
        end

    // every output pixel sits inside the output frame
    de_in_frame: assert property (@(posedge clk) disable iff (!arst_n_i)
        out_de_i |-> out_vs_i)
        else begin
            fail_cnt++;
            $error("de_o high while vs_o is low");
        end

    // no pixel comes out of a reset
    de_after_reset: assert property (@(posedge clk) !arst_n_i |=> !out_de_i)
        else begin
            fail_cnt++;
            $error("de_o high right after reset");
        end

endmodule

bind img_filter_top img_filter_props props_i (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pslverr_i (pslverr_o),
    .out_de_i  (de_o),
    .out_vs_i  (vs_o)
);

`default_nettype wire

// ==== tb/img_filter_tb.sv ====
// directed testbench for the 7x7 image filter, simulate with the file list and img_filter_tb on top
`timescale 1ns/100ps
`default_nettype none
`include "img_filter_defines.svh"

module img_filter_tb;
    import img_filter_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DLY   = 10;
    localparam int HBLANK      = 4;
    localparam int MAX_W       = 32;
    localparam int MAX_H       = 16;
    localparam int PIX_MAX     = (1 << `PIX_W) - 1;
    localparam int FILL_INDEX  = 0;
    localparam int FILL_RANDOM = 1;
    localparam int FILL_FULL   = 2;
    // six 12x10 frames and two 16x12 frames, each with its blanking
    localparam int FRAME_SUM   = 6 * (10 * (12 + HBLANK) + 4) + 2 * (12 * (16 + HBLANK) + 4);
    localparam int WATCH_CYC   = 4 * FRAME_SUM + 4000;

    logic              clk;
    logic              arst_n_i;
    logic              psel_i;
    logic              penable_i;
    logic              pwrite_i;
    logic [3:0]        paddr_i;
    logic [31:0]       pwdata_i;
    logic [31:0]       prdata_o;
    logic              pready_o;
    logic              pslverr_o;
    logic [`PIX_W-1:0] pix_i;
    logic              de_i;
    logic              hs_i;
    logic              vs_i;
    logic [`PIX_W-1:0] pix_o;
    logic              de_o;
    logic              vs_o;

    logic [`PIX_W-1:0] frame_mem [0:MAX_H-1][0:MAX_W-1];
    logic [`PIX_W-1:0] exp_q [$];
    logic [`PIX_W-1:0] got_q [$];

    img_filter_top dut_i (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .pix_i     (pix_i),
        .de_i      (de_i),
        .hs_i      (hs_i),
        .vs_i      (vs_i),
        .pix_o     (pix_o),
        .de_o      (de_o),
        .vs_o      (vs_o)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // output pixels in arrival order
    always @(negedge clk) begin
        if (arst_n_i && de_o) begin
            got_q.push_back(pix_o);
        end
    end

    // ----------------------------------------
    // common helpers
    // ----------------------------------------
    task automatic step();
        @(posedge clk);
        #(DRIVE_DLY);
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_pix(input string name, input logic [`PIX_W-1:0] got,
                             input logic [`PIX_W-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_reg(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_mode(input string name, input kernel_mode_e got,
                              input kernel_mode_e exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic apply_reset();
        arst_n_i = 1'b0;
        repeat (16) step();
        arst_n_i = 1'b1;
        step();
    endtask

    // ----------------------------------------
    // APB master
    // ----------------------------------------
    task automatic set_phase(input apb_state_e ph);
        psel_i    = (ph != APB_IDLE);
        penable_i = (ph == APB_ACCESS);
    endtask

    // no wait states, so pready_o must already be high in the access cycle
    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
        paddr_i  = addr;
        pwdata_i = data;
        pwrite_i = 1'b1;
        set_phase(APB_SETUP);
        step();
        set_phase(APB_ACCESS);
        @(negedge clk);
        check_flag("pready_o", pready_o, 1'b1);
        step();
        set_phase(APB_IDLE);
        pwrite_i = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic err);
        paddr_i  = addr;
        pwrite_i = 1'b0;
        set_phase(APB_SETUP);
        step();
        set_phase(APB_ACCESS);
        @(negedge clk);
        check_flag("pready_o", pready_o, 1'b1);
        data = prdata_o;
        err  = pslverr_o;
        step();
        set_phase(APB_IDLE);
    endtask

    // enable in bit 0, mode in 5:4, shift in 11:8
    function automatic logic [31:0] ctrl_word(input logic en, input kernel_mode_e mode,
                                              input int shift);
        return {20'd0, shift[3:0], 2'd0, mode, 3'd0, en};
    endfunction

    // ----------------------------------------
    // video source and reference model
    // ----------------------------------------
    task automatic drive_video(input logic de, input logic [`PIX_W-1:0] pix, input logic hs,
                               input logic vs);
        de_i  = de;
        pix_i = pix;
        hs_i  = hs;
        vs_i  = vs;
        step();
    endtask

    task automatic fill_frame(input int w, input int h, input int kind);
        for (int r = 0; r < h; r++) begin
            for (int c = 0; c < w; c++) begin
                case (kind)
                    FILL_INDEX:  frame_mem[r][c] = r * MAX_W + c;
                    FILL_RANDOM: frame_mem[r][c] = $urandom;
                    default:     frame_mem[r][c] = PIX_MAX;
                endcase
            end
        end
    endtask

    // short_row below zero sends every line at full length
    task automatic send_frame(input int w, input int h, input bit gaps, input int short_row);
        int len;
        int idle;
        drive_video(1'b0, '0, 1'b1, 1'b1);
        drive_video(1'b0, '0, 1'b1, 1'b1);
        for (int r = 0; r < h; r++) begin
            len = (r == short_row) ? w - 2 : w;
            for (int c = 0; c < len; c++) begin
                idle = gaps ? ($urandom % 4) : 0;
                repeat (idle) drive_video(1'b0, '0, 1'b0, 1'b1);
                drive_video(1'b1, frame_mem[r][c], 1'b0, 1'b1);
            end
            repeat (HBLANK) drive_video(1'b0, '0, 1'b1, 1'b1);
        end
        drive_video(1'b0, '0, 1'b0, 1'b0);
    endtask

    // vs_o still high just after the frame when enabled
    // then drops once the last window has left the pipeline
    task automatic wait_frame_out(input logic en);
        @(negedge clk);
        check_flag("vs_o", vs_o, en);
        while (vs_o) @(negedge clk);
        step();
    endtask

    // one output per pixel at row >= 6 and column >= 6, centred three back in both
    task automatic build_expected(input int w, input int h, input kernel_mode_e mode,
                                  input int shift);
        int sum;
        int reach;
        exp_q.delete();
        reach = (mode == MODE_BOX7) ? 3 : ((mode == MODE_BOX3) ? 1 : 0);
        for (int r = 6; r < h; r++) begin
            for (int c = 6; c < w; c++) begin
                sum = 0;
                for (int dr = -reach; dr <= reach; dr++) begin
                    for (int dc = -reach; dc <= reach; dc++) begin
                        sum += frame_mem[r - 3 + dr][c - 3 + dc];
                    end
                end
                sum = sum >> shift;
                if (sum > PIX_MAX) begin
                    sum = PIX_MAX;
                end
                exp_q.push_back(sum[`PIX_W-1:0]);
            end
        end
    endtask

    task automatic compare_output(input string label);
        if (got_q.size() != exp_q.size()) begin
            fail_run($sformatf("%s: %0d output pixels seen where %0d were expected",
                               label, got_q.size(), exp_q.size()));
        end
        foreach (exp_q[i]) begin
            check_pix($sformatf("%s pix_o[%0d]", label, i), got_q[i], exp_q[i]);
        end
    endtask

    task automatic run_filter_frame(input string label, input int w, input int h,
                                    input kernel_mode_e mode, input int shift,
                                    input int kind, input bit gaps);
        apb_write(`REG_WIDTH, w);
        apb_write(`REG_CTRL, ctrl_word(1'b1, mode, shift));
        fill_frame(w, h, kind);
        build_expected(w, h, mode, shift);
        got_q.delete();
        send_frame(w, h, gaps, -1);
        wait_frame_out(1'b1);
        compare_output(label);
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic reg_access();
        logic [31:0] rd;
        logic        err;
        apb_write(`REG_CTRL, ctrl_word(1'b1, MODE_BOX7, 5));
        apb_read(`REG_CTRL, rd, err);
        check_flag("pslverr_o", err, 1'b0);
        check_reg("CTRL", rd, 32'h0000_0521);
        check_mode("CTRL.mode", kernel_mode_e'(rd[5:4]), MODE_BOX7);
        // reserved mode code
        apb_write(`REG_CTRL, 32'h0000_0331);
        apb_read(`REG_CTRL, rd, err);
        check_mode("CTRL.mode", kernel_mode_e'(rd[5:4]), MODE_CENTER);
        check_reg("CTRL", rd, 32'h0000_0301);
        apb_write(`REG_WIDTH, 32'd180);
        apb_read(`REG_WIDTH, rd, err);
        check_reg("WIDTH", rd, 32'd180);
        apb_read(4'hC, rd, err);
        check_flag("pslverr_o", err, 1'b1);
        check_reg("prdata_o", rd, 32'h0);
        apb_write(`REG_CTRL, 32'h0);
    endtask

    task automatic center_pass();
        run_filter_frame("centre", 12, 10, MODE_CENTER, 0, FILL_INDEX, 1'b0);
    endtask

    task automatic box_sums();
        run_filter_frame("box3", 16, 12, MODE_BOX3, 3, FILL_RANDOM, 1'b1);
        run_filter_frame("box7", 16, 12, MODE_BOX7, 5, FILL_RANDOM, 1'b1);
    endtask

    task automatic clamp_full_scale();
        run_filter_frame("clamp", 12, 10, MODE_BOX7, 0, FILL_FULL, 1'b0);
        foreach (got_q[i]) begin
            check_pix($sformatf("clamp pix_o[%0d]", i), got_q[i], PIX_MAX);
        end
    endtask

    task automatic status_counts();
        logic [31:0] rd;
        logic        err;
        apply_reset();
        apb_write(`REG_WIDTH, 12);
        apb_write(`REG_CTRL, ctrl_word(1'b1, MODE_CENTER, 0));
        fill_frame(12, 10, FILL_RANDOM);
        repeat (2) begin
            send_frame(12, 10, 1'b0, -1);
            wait_frame_out(1'b1);
        end
        apb_read(`REG_STATUS, rd, err);
        check_reg("STATUS", rd, 32'h0000_0002);
        // line 4 two pixels short of WIDTH
        send_frame(12, 10, 1'b0, 4);
        wait_frame_out(1'b1);
        apb_read(`REG_STATUS, rd, err);
        check_reg("STATUS", rd, 32'h0001_0003);
        apb_write(`REG_STATUS, 32'h0001_0000);
        apb_read(`REG_STATUS, rd, err);
        check_reg("STATUS", rd, 32'h0000_0003);
    endtask

    task automatic disable_stream();
        apb_write(`REG_WIDTH, 12);
        apb_write(`REG_CTRL, ctrl_word(1'b0, MODE_BOX3, 1));
        fill_frame(12, 10, FILL_RANDOM);
        got_q.delete();
        send_frame(12, 10, 1'b0, -1);
        wait_frame_out(1'b0);
        check_reg("de_o pixel count", got_q.size(), 32'd0);
    endtask

    // ----------------------------------------
    // watchdog and main sequence
    // ----------------------------------------
    initial begin
        repeat (WATCH_CYC) @(posedge clk);
        fail_run("watchdog expired before the tests completed");
    end

    initial begin
        void'($urandom(32'h72c9));
        arst_n_i  = 1'b0;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = '0;
        pwdata_i  = '0;
        pix_i     = '0;
        de_i      = 1'b0;
        hs_i      = 1'b0;
        vs_i      = 1'b0;
        apply_reset();
        reg_access();
        center_pass();
        box_sums();
        clamp_full_scale();
        status_counts();
        disable_stream();
        if (dut_i.props_i.fail_cnt != 0) begin
            fail_run("bound assertions reported failures");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== img_filter_top.f ====
+incdir+hdl
hdl/img_filter_pkg.sv
hdl/filter_csr_decode.sv
hdl/window_7x7.sv
hdl/kernel_sum.sv
hdl/pixel_normalize.sv
hdl/img_filter_top.sv
tb/img_filter_props.sv
tb/img_filter_tb.sv
